// File: hdl/wb_consts.svh
// ----------------------------------------
// Writeback subsystem constants
// Sizes of the reorder buffer, slot pool and register file
// ----------------------------------------
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// Reorder buffer entries, one per tag
`define WB_ROB_DEPTH 8
// Execution slots in the pool
`define WB_SLOTS 4
// Architectural registers
`define WB_NUM_REGS 16
// Data word width
`define WB_DATA_BITS 32
// Width of the per-operation delay field
`define WB_DELAY_BITS 3

`endif

// File: hdl/isa_pkg.sv
// ----------------------------------------
// Architectural types
// Opcodes, register indices and data words
// ----------------------------------------
`include "wb_consts.svh"

package isa_pkg;

  // Index width follows the register count
  localparam int REG_BITS = $clog2(`WB_NUM_REGS);

  // ALU opcodes
  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    XOR = 2'd2,
    AND = 2'd3
  } op_t;

  // Architectural register index
  typedef logic [REG_BITS-1:0] reg_idx_t;

  // Data word
  typedef logic [`WB_DATA_BITS-1:0] word_t;

endpackage

// File: hdl/wb_pkg.sv
// ----------------------------------------
// Microarchitectural types
// Reorder buffer tag and completion message
// ----------------------------------------
`include "wb_consts.svh"

package wb_pkg;

  // One tag per reorder buffer entry
  localparam int TAG_BITS = $clog2(`WB_ROB_DEPTH);

  typedef logic [TAG_BITS-1:0] tag_t;

  // Completion message
  // Tag is the ROB index and is not carried here
  typedef struct packed {
    isa_pkg::reg_idx_t dest;
    isa_pkg::word_t    data;
  } cmpl_t;

endpackage

// File: hdl/tag_alloc.sv
// ----------------------------------------
// Tag allocator
// Hands out ROB tags in program order and
// answers the four-phase dispatch handshake
// ----------------------------------------
`timescale 1ns/1ns
`include "wb_consts.svh"

module tag_alloc (
  input  logic         clk,
  input  logic         rst,
  input  logic         disp_req,
  output logic         disp_ack,
  input  logic         slot_free,
  input  logic         retire,
  output logic         alloc_fire,
  output wb_pkg::tag_t alloc_tag
);

  localparam int DEPTH    = `WB_ROB_DEPTH;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  logic [CNT_BITS-1:0] in_flight;
  logic                space;
  logic                accept;

  // Room needed in both the ROB and the slot pool
  assign space  = (in_flight < CNT_BITS'(DEPTH)) && slot_free;
  // New request only while ack is low
  assign accept = disp_req && !disp_ack && space;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      disp_ack   <= 1'b0;
      alloc_fire <= 1'b0;
    end else begin
      // Fire pulses in the cycle ack rises
      alloc_fire <= accept;
      if (accept) begin
        disp_ack <= 1'b1;
      end else if (disp_ack && !disp_req) begin
        // Source has let go of req
        disp_ack <= 1'b0;
      end
    end
  end

  // Next tag, wrap at buffer depth
  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_tag <= '0;
    end else if (alloc_fire) begin
      if (alloc_tag == wb_pkg::tag_t'(DEPTH - 1)) begin
        alloc_tag <= '0;
      end else begin
        alloc_tag <= alloc_tag + 1'b1;
      end
    end
  end

  // Tags between allocation and retire
  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      case ({alloc_fire, retire})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

endmodule

// File: hdl/exec_pool.sv
// ----------------------------------------
// Execution slot pool
// Computes results, holds each for its delay and
// releases one completion per cycle
// ----------------------------------------
`timescale 1ns/1ns
`include "wb_consts.svh"

module exec_pool (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      alloc_fire,
  input  wb_pkg::tag_t              alloc_tag,
  input  isa_pkg::op_t              op,
  input  isa_pkg::reg_idx_t         dest,
  input  isa_pkg::word_t            a,
  input  isa_pkg::word_t            b,
  input  logic [`WB_DELAY_BITS-1:0] delay,
  output logic                      slot_free,
  output logic                      cmpl_val,
  output wb_pkg::tag_t              cmpl_tag,
  output wb_pkg::cmpl_t             cmpl_msg
);

  localparam int SLOTS     = `WB_SLOTS;
  localparam int SLOT_BITS = $clog2(SLOTS);

  // Per-slot state
  logic                      busy  [SLOTS];
  logic [`WB_DELAY_BITS-1:0] count [SLOTS];
  wb_pkg::tag_t              s_tag [SLOTS];
  wb_pkg::cmpl_t             s_msg [SLOTS];

  logic [SLOTS-1:0]     free_vec;
  logic [SLOTS-1:0]     ready_vec;
  logic [SLOT_BITS-1:0] load_sel;
  logic [SLOT_BITS-1:0] pick_sel;
  logic                 pick_any;

  // Opcode rule, wraps modulo word width
  function automatic isa_pkg::word_t alu(isa_pkg::op_t f_op,
                                         isa_pkg::word_t x,
                                         isa_pkg::word_t y);
    case (f_op)
      isa_pkg::ADD: return x + y;
      isa_pkg::SUB: return x - y;
      isa_pkg::XOR: return x ^ y;
      default:      return x & y;
    endcase
  endfunction

  // Fixed priority, lowest set bit wins
  function automatic logic [SLOT_BITS-1:0] lowest(logic [SLOTS-1:0] vec);
    logic [SLOT_BITS-1:0] idx;
    idx = '0;
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = SLOT_BITS'(i);
      end
    end
    return idx;
  endfunction

  // ----------------------------------------
  // Slot selection
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < SLOTS; i++) begin
      free_vec[i]  = !busy[i];
      // Ready once the countdown hits zero
      ready_vec[i] = busy[i] && (count[i] == '0);
    end
  end

  assign slot_free = |free_vec;
  assign pick_any  = |ready_vec;
  assign load_sel  = lowest(free_vec);
  assign pick_sel  = lowest(ready_vec);

  // Occupancy and timers
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < SLOTS; i++) begin
        busy[i]  <= 1'b0;
        count[i] <= '0;
      end
      cmpl_val <= 1'b0;
    end else begin
      for (int i = 0; i < SLOTS; i++) begin
        if (busy[i] && count[i] != '0) begin
          count[i] <= count[i] - 1'b1;
        end
      end
      // Released slot is busy so never the load target
      if (pick_any) begin
        busy[pick_sel] <= 1'b0;
      end
      if (alloc_fire) begin
        busy[load_sel]  <= 1'b1;
        count[load_sel] <= delay;
      end
      cmpl_val <= pick_any;
    end
  end

  // Payload and completion registers
  always_ff @(posedge clk) begin
    if (alloc_fire) begin
      s_tag[load_sel]      <= alloc_tag;
      s_msg[load_sel].dest <= dest;
      s_msg[load_sel].data <= alu(op, a, b);
    end
    if (pick_any) begin
      cmpl_tag <= s_tag[pick_sel];
      cmpl_msg <= s_msg[pick_sel];
    end
  end

endmodule

// File: hdl/reorder_buffer.sv
// ----------------------------------------
// Reorder buffer
// Stores completions by tag and releases them
// in order from a wrapping head pointer
// ----------------------------------------
`timescale 1ns/1ns
`include "wb_consts.svh"

module reorder_buffer (
  input  logic          clk,
  input  logic          rst,

  // Insert side, out of order
  input  logic          ins_en,
  input  wb_pkg::tag_t  ins_idx,
  input  wb_pkg::cmpl_t ins_msg,

  // Dequeue side, in order
  input  logic          deq_en,
  output logic          deq_rdy,
  output wb_pkg::tag_t  deq_idx,
  output wb_pkg::cmpl_t deq_msg
);

  localparam int DEPTH = `WB_ROB_DEPTH;

  // Entry storage
  logic          val [DEPTH];
  wb_pkg::cmpl_t mem [DEPTH];

  wb_pkg::tag_t head;
  wb_pkg::tag_t head_next;
  logic         at_head;
  logic         bypass;
  logic         deq_fire;

  // ----------------------------------------
  // Bypass
  // ----------------------------------------
  // Completion landing on the head entry
  assign at_head = ins_en && (ins_idx == head);
  // Goes straight out, never written
  assign bypass  = at_head && deq_en;

  assign deq_rdy  = val[head] || at_head;
  assign deq_fire = deq_en && deq_rdy;
  assign deq_msg  = at_head ? ins_msg : mem[head];
  // Bypass only happens at the head index
  assign deq_idx  = head;

  // Head advance with wrap
  always_comb begin
    if (head == wb_pkg::tag_t'(DEPTH - 1)) begin
      head_next = '0;
    end else begin
      head_next = head + 1'b1;
    end
  end

  // ----------------------------------------
  // Valid flags and head
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        val[i] <= 1'b0;
      end
      head <= '0;
    end else begin
      if (ins_en && !bypass) begin
        val[ins_idx] <= 1'b1;
      end
      if (deq_fire) begin
        val[head] <= 1'b0;
        head      <= head_next;
      end
    end
  end

  // Message array
  always_ff @(posedge clk) begin
    if (ins_en && !bypass) begin
      mem[ins_idx] <= ins_msg;
    end
  end

endmodule

// File: hdl/commit_regfile.sv
// ----------------------------------------
// Commit stage and register file
// Retires results in order and reports each commit
// ----------------------------------------
`timescale 1ns/1ns
`include "wb_consts.svh"

module commit_regfile (
  input  logic              clk,
  input  logic              rst,
  input  logic              deq_rdy,
  input  wb_pkg::tag_t      deq_idx,
  input  wb_pkg::cmpl_t     deq_msg,
  output logic              deq_en,
  output logic              retire,
  output logic              commit_val,
  output wb_pkg::tag_t      commit_tag,
  output isa_pkg::reg_idx_t commit_dest,
  output isa_pkg::word_t    commit_data,
  input  isa_pkg::reg_idx_t rd_addr,
  output isa_pkg::word_t    rd_data
);

  localparam int NUM_REGS = `WB_NUM_REGS;

  // Architectural state
  isa_pkg::word_t regs [NUM_REGS];

  // Commit never stalls
  assign deq_en = 1'b1;
  assign retire = deq_en && deq_rdy;

  // Register writes, all zero out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      commit_val <= 1'b0;
    end else begin
      if (retire) begin
        regs[deq_msg.dest] <= deq_msg.data;
      end
      commit_val <= retire;
    end
  end

  // Commit report one cycle after dequeue
  always_ff @(posedge clk) begin
    if (retire) begin
      commit_tag  <= deq_idx;
      commit_dest <= deq_msg.dest;
      commit_data <= deq_msg.data;
    end
  end

  // Software read port
  assign rd_data = regs[rd_addr];

endmodule

// File: hdl/writeback_top.sv
// ----------------------------------------
// Writeback subsystem top
// Dispatch, execute out of order, reorder, commit
// ----------------------------------------
`timescale 1ns/1ns
`include "wb_consts.svh"

module writeback_top (
  input  logic                      clk,
  input  logic                      rst,

  // Dispatch port
  input  logic                      disp_req,
  output logic                      disp_ack,
  input  isa_pkg::op_t              disp_op,
  input  isa_pkg::reg_idx_t         disp_dest,
  input  isa_pkg::word_t            disp_a,
  input  isa_pkg::word_t            disp_b,
  input  logic [`WB_DELAY_BITS-1:0] disp_delay,

  // Register read
  input  isa_pkg::reg_idx_t         rd_addr,
  output isa_pkg::word_t            rd_data,

  // Commit report
  output logic                      commit_val,
  output wb_pkg::tag_t              commit_tag,
  output isa_pkg::reg_idx_t         commit_dest,
  output isa_pkg::word_t            commit_data
);

  // Allocation
  logic          alloc_fire;
  wb_pkg::tag_t  alloc_tag;
  logic          slot_free;
  logic          retire;

  // Completion into the ROB
  logic          cmpl_val;
  wb_pkg::tag_t  cmpl_tag;
  wb_pkg::cmpl_t cmpl_msg;

  // ROB dequeue
  logic          deq_en;
  logic          deq_rdy;
  wb_pkg::tag_t  deq_idx;
  wb_pkg::cmpl_t deq_msg;

  tag_alloc tag_alloc_i (
    .clk        (clk),
    .rst        (rst),
    .disp_req   (disp_req),
    .disp_ack   (disp_ack),
    .slot_free  (slot_free),
    .retire     (retire),
    .alloc_fire (alloc_fire),
    .alloc_tag  (alloc_tag)
  );

  // Fields are still stable on the fire edge
  exec_pool exec_pool_i (
    .clk        (clk),
    .rst        (rst),
    .alloc_fire (alloc_fire),
    .alloc_tag  (alloc_tag),
    .op         (disp_op),
    .dest       (disp_dest),
    .a          (disp_a),
    .b          (disp_b),
    .delay      (disp_delay),
    .slot_free  (slot_free),
    .cmpl_val   (cmpl_val),
    .cmpl_tag   (cmpl_tag),
    .cmpl_msg   (cmpl_msg)
  );

  reorder_buffer reorder_buffer_i (
    .clk     (clk),
    .rst     (rst),
    .ins_en  (cmpl_val),
    .ins_idx (cmpl_tag),
    .ins_msg (cmpl_msg),
    .deq_en  (deq_en),
    .deq_rdy (deq_rdy),
    .deq_idx (deq_idx),
    .deq_msg (deq_msg)
  );

  commit_regfile commit_regfile_i (
    .clk         (clk),
    .rst         (rst),
    .deq_rdy     (deq_rdy),
    .deq_idx     (deq_idx),
    .deq_msg     (deq_msg),
    .deq_en      (deq_en),
    .retire      (retire),
    .commit_val  (commit_val),
    .commit_tag  (commit_tag),
    .commit_dest (commit_dest),
    .commit_data (commit_data),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
  );

endmodule

// File: test/writeback_properties.sv
// ----------------------------------------
// Writeback assertions
// Dispatch handshake rules and in-order commit tags
// ----------------------------------------
`timescale 1ns/1ns
`include "wb_consts.svh"

module writeback_properties (
  input logic                      clk,
  input logic                      rst,
  input logic                      disp_req,
  input logic                      disp_ack,
  input isa_pkg::op_t              disp_op,
  input isa_pkg::reg_idx_t         disp_dest,
  input isa_pkg::word_t            disp_a,
  input isa_pkg::word_t            disp_b,
  input logic [`WB_DELAY_BITS-1:0] disp_delay,
  input logic                      commit_val,
  input wb_pkg::tag_t              commit_tag
);

  wb_pkg::tag_t last_tag;
  logic         seen_commit;

  // Number of assertion failures so far
  int           assert_errors = 0;

  // Tag of the previous commit pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      seen_commit <= 1'b0;
      last_tag    <= '0;
    end else if (commit_val) begin
      seen_commit <= 1'b1;
      last_tag    <= commit_tag;
    end
  end

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    !disp_req && !disp_ack |=> !disp_ack)
    else begin
      $error("disp_ack rose with no request pending");
      assert_errors++;
    end

  // Fields held until the sink answers
  fields_stable: assert property (@(posedge clk) disable iff (rst)
    disp_req && !disp_ack |=> $stable(disp_op) && $stable(disp_dest) &&
      $stable(disp_a) && $stable(disp_b) && $stable(disp_delay))
    else begin
      $error("Dispatch fields changed while the request waited");
      assert_errors++;
    end

  // Depth is a power of two so the tag wraps by itself
  tag_in_order: assert property (@(posedge clk) disable iff (rst)
    commit_val && seen_commit |-> commit_tag == wb_pkg::tag_t'(last_tag + 1'b1))
    else begin
      $error("commit_tag skipped or repeated a value");
      assert_errors++;
    end

endmodule

bind writeback_top writeback_properties writeback_properties_i (
  .clk (clk), .rst (rst), .disp_req (disp_req), .disp_ack (disp_ack),
  .disp_op (disp_op), .disp_dest (disp_dest), .disp_a (disp_a),
  .disp_b (disp_b), .disp_delay (disp_delay), .commit_val (commit_val),
  .commit_tag (commit_tag)
);

// File: test/writeback_tb.sv
// ----------------------------------------
// Writeback subsystem testbench
// Replays testdata through dispatch, checks commits
// and the final register file state
// ----------------------------------------
`timescale 1ns/1ns
`include "wb_consts.svh"

module writeback_tb;

  localparam int MEM_WORDS  = 256;
  localparam int REC_WORDS  = 6;
  localparam int WAIT_LIMIT = 200;
  localparam int DEPTH      = `WB_ROB_DEPTH;
  localparam int NUM_REGS   = `WB_NUM_REGS;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      disp_req;
  logic                      disp_ack;
  isa_pkg::op_t              disp_op;
  isa_pkg::reg_idx_t         disp_dest;
  isa_pkg::word_t            disp_a;
  isa_pkg::word_t            disp_b;
  logic [`WB_DELAY_BITS-1:0] disp_delay;
  isa_pkg::reg_idx_t         rd_addr;
  isa_pkg::word_t            rd_data;
  logic                      commit_val;
  wb_pkg::tag_t              commit_tag;
  isa_pkg::reg_idx_t         commit_dest;
  isa_pkg::word_t            commit_data;

  // Word 0 is the count, then records, then final registers
  logic [31:0] tdata [MEM_WORDS];
  logic [31:0] lfsr;
  int          num_ops;
  int          sent_count;
  int          commit_count;
  int          value_errors;
  int          timeout_errors;

  // 4 ns period
  always #2 clk = ~clk;

  writeback_top writeback_top_i (
    .clk (clk), .rst (rst),
    .disp_req (disp_req), .disp_ack (disp_ack), .disp_op (disp_op),
    .disp_dest (disp_dest), .disp_a (disp_a), .disp_b (disp_b),
    .disp_delay (disp_delay), .rd_addr (rd_addr), .rd_data (rd_data),
    .commit_val (commit_val), .commit_tag (commit_tag),
    .commit_dest (commit_dest), .commit_data (commit_data)
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | lfsr[0];
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic finish_run();
    int assert_errors;
    assert_errors = writeback_top_i.writeback_properties_i.assert_errors;
    $display("Errors: %0d value, %0d timeout, %0d assertion, %0d of %0d committed",
             value_errors, timeout_errors, assert_errors, commit_count, num_ops);
    if (value_errors == 0 && timeout_errors == 0 && assert_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout at %0t: %s", $time, what);
    timeout_errors++;
  endtask

  // ----------------------------------------
  // Four-phase dispatch driver
  // ----------------------------------------
  task automatic dispatch_op(input int idx);
    int base;
    int waited;
    int gap;
    base = 1 + idx * REC_WORDS;
    @(posedge clk);
    disp_op    <= isa_pkg::op_t'(tdata[base][1:0]);
    disp_dest  <= isa_pkg::reg_idx_t'(tdata[base+1]);
    disp_a     <= tdata[base+2];
    disp_b     <= tdata[base+3];
    disp_delay <= tdata[base+4][`WB_DELAY_BITS-1:0];
    disp_req   <= 1'b1;
    // Ack may be withheld while the pool or ROB is full
    waited = 0;
    @(negedge clk);
    while (!disp_ack && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!disp_ack) begin
      timeout_fail("disp_ack never rose for a pending request");
    end else begin
      sent_count++;
      // Fields stay put through the load edge
      @(posedge clk);
      disp_req <= 1'b0;
      waited = 0;
      @(negedge clk);
      while (disp_ack && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (disp_ack) begin
        timeout_fail("disp_ack stayed high after the request dropped");
      end else begin
        // Random idle gap of 0 to 3 cycles
        take_bits(2, gap);
        repeat (gap) @(posedge clk);
      end
    end
  endtask

  // ----------------------------------------
  // Commit monitor
  // ----------------------------------------
  task automatic check_commit();
    int base;
    base = 1 + commit_count * REC_WORDS;
    if (commit_count >= sent_count) begin
      $display("Commit with tag %h seen but no dispatched operation is left", commit_tag);
      value_errors++;
    end else begin
      // Program order, tag wraps at the ROB depth
      check_value("commit_tag", commit_tag, commit_count % DEPTH);
      check_value("commit_dest", commit_dest, tdata[base+1]);
      check_value("commit_data", commit_data, tdata[base+5]);
    end
    commit_count++;
  endtask

  always @(negedge clk) begin
    if (!rst && commit_val) begin
      check_commit();
    end
  end

  // Main sequence
  initial begin
    int waited;
    int reg_base;
    rst            = 1'b1;
    disp_req       = 1'b0;
    disp_op        = isa_pkg::ADD;
    disp_dest      = '0;
    disp_a         = '0;
    disp_b         = '0;
    disp_delay     = '0;
    rd_addr        = '0;
    lfsr           = 32'h53b2d8b5;
    sent_count     = 0;
    commit_count   = 0;
    value_errors   = 0;
    timeout_errors = 0;
    $readmemh("test/writeback_testdata.txt", tdata);
    num_ops  = tdata[0];
    reg_base = 1 + num_ops * REC_WORDS;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < num_ops && timeout_errors == 0; i++) begin
      dispatch_op(i);
    end
    // Drain the pipeline
    waited = 0;
    while (timeout_errors == 0 && commit_count < num_ops && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (timeout_errors == 0 && commit_count < num_ops) begin
      timeout_fail("not every dispatched operation committed");
    end
    if (timeout_errors == 0) begin
      // Quiet window to catch a duplicate commit
      repeat (20) @(negedge clk);
      check_value("commit count", commit_count, num_ops);
      // Later writes to a register win
      for (int r = 0; r < NUM_REGS; r++) begin
        @(posedge clk);
        rd_addr <= isa_pkg::reg_idx_t'(r);
        @(negedge clk);
        check_value($sformatf("rd_data[%0d]", r), rd_data, tdata[reg_base+r]);
      end
    end
    finish_run();
  end

endmodule

// File: test/writeback_testdata.txt
// First word: number of operation records
// Records: op (0 ADD, 1 SUB, 2 XOR, 3 AND), dest, a, b, delay, expected result
// Last section: expected final values of registers 0 to 15
00000014
1 1 00000010 00000003 0 0000000d
0 2 00000005 00000007 7 0000000c
0 3 00000001 00000001 0 00000002
2 4 ff00ff00 0f0f0f0f 1 f00ff00f
3 5 12345678 0000ffff 2 00005678
1 6 00000000 00000001 0 ffffffff
0 7 ffffffff 00000002 3 00000001
0 2 00000100 00000023 6 00000123
// Burst of long delays
2 8 aaaaaaaa 55555555 7 ffffffff
3 9 aaaaaaaa 0000ffff 6 0000aaaa
0 a 80000000 80000000 7 00000000
1 b 00001000 00000001 5 00000fff
0 c 00000abc 00000111 7 00000bcd
2 d 0000ffff 00ff00ff 6 00ffff00
3 e deadbeef ffff0000 7 dead0000
1 f 00000000 00000010 7 fffffff0
// Long op then short ones behind it
0 1 00000020 00000022 7 00000042
0 3 00000003 00000004 0 00000007
1 4 00000064 00000014 0 00000050
3 0 0000ff00 0000f0f0 1 0000f000
// Final registers
0000f000 00000042 00000123 00000007
00000050 00005678 ffffffff 00000001
ffffffff 0000aaaa 00000000 00000fff
00000bcd 00ffff00 dead0000 fffffff0

// File: all.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/wb_pkg.sv
hdl/tag_alloc.sv
hdl/exec_pool.sv
hdl/reorder_buffer.sv
hdl/commit_regfile.sv
hdl/writeback_top.sv
test/writeback_properties.sv
test/writeback_tb.sv
